/* source/samc_defs.svh */
`ifndef SAMC_DEFS_SVH
`define SAMC_DEFS_SVH

// ======================================================================
// ASIC port numbers, low byte of the I/O address
// ======================================================================
`define SAMC_PORT_LMPR   8'hFA
`define SAMC_PORT_HMPR   8'hFB
`define SAMC_PORT_STAT   8'hF9
`define SAMC_PORT_BRDR   8'hFE
`define SAMC_PORT_MIDI   8'hFD
`define SAMC_PORT_LPTD   8'hE8  // VOX sample data
`define SAMC_PORT_LPTS   8'hE9  // VOX strobe
`define SAMC_PORT_EXTC   8'h80  // External RAM page, section C
`define SAMC_PORT_EXTD   8'h81  // External RAM page, section D

// ======================================================================
// Memory map
// ======================================================================
`define SAMC_RAM_AW      25
`define SAMC_ROM_PAGE    5'h10
`define SAMC_EXT_BASE    9'h40  // First 16K page of external RAM

// ======================================================================
// MIDI and audio
// ======================================================================
`define SAMC_MEG_DIV     96     // clk_sys cycles per 1 MHz tick
`define SAMC_MIDI_TIME   320    // One byte at 31.25 kbaud, in ticks
`define SAMC_MIDI_INT_AT 15
`define SAMC_SAMPLE_W    18

`endif

/* source/samc_pkg.sv */
`include "samc_defs.svh"

package samc_pkg;

	// One CPU bus cycle, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
		logic        rfsh;
	} cpu_bus_t;

	// LMPR bit layout
	typedef struct packed {
		logic       wp;        // Write protect section A
		logic       rom1_en;   // ROM1 in section D
		logic       rom0_off;  // RAM instead of ROM0 in section A
		logic [4:0] page_ab;
	} lmpr_bits_t;

	typedef union packed {
		logic [7:0] raw;
		lmpr_bits_t f;
	} lmpr_t;

	// HMPR bit layout
	typedef struct packed {
		logic       ext_ram;   // External RAM above 8000
		logic [1:0] mode3_hi;  // Mode 3 colour bits, video side only
		logic [4:0] page_cd;
	} hmpr_bits_t;

	typedef union packed {
		logic [7:0] raw;
		hmpr_bits_t f;
	} hmpr_t;

	// Everything the address mapper needs
	typedef struct packed {
		lmpr_t      lmpr;
		hmpr_t      hmpr;
		logic [7:0] ext_c;
		logic [7:0] ext_d;
		logic       ext_dis;
	} page_state_t;

	typedef struct packed {
		logic [`SAMC_RAM_AW-1:0] ram_addr;
		logic                    we;
		logic                    rd;
	} mem_req_t;

	typedef struct packed {
		logic [`SAMC_SAMPLE_W-1:0] left;
		logic [`SAMC_SAMPLE_W-1:0] right;
	} audio_t;

endpackage

/* source/asic_port_regs.sv */
`timescale 1ns/1ps
`include "samc_defs.svh"

module asic_port_regs import samc_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  cpu_bus_t    bus,
	input  logic        ext_ram_off,
	input  logic        int_midi,
	output page_state_t pages,
	output logic        ear,
	output logic        port_wr,
	output logic        midi_wr,
	output logic [7:0]  io_dout,
	output logic        io_dout_en
);

	logic       port_we;
	logic       port_rd;
	logic       old_we;
	lmpr_t      lmpr;
	hmpr_t      hmpr;
	logic [7:0] brdr;
	logic [7:0] ext_c;
	logic [7:0] ext_d;
	logic       ext_dis;

	assign port_we = bus.iorq & bus.wr & bus.m1;
	assign port_rd = bus.iorq & bus.rd & bus.m1;

	// Acts only on the first cycle of a held strobe
	assign port_wr = port_we & ~old_we;
	assign midi_wr = port_wr & (bus.addr[7:0] == `SAMC_PORT_MIDI);

	// ======================================================================
	// Write-side registers
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_we  <= 1'b0;
			lmpr    <= '0;
			hmpr    <= '0;
			brdr    <= '0;
			ext_c   <= '0;
			ext_d   <= '0;
			ext_dis <= ext_ram_off; // Sampled config bit
		end else begin
			old_we <= port_we;
			if (port_wr) begin
				case (bus.addr[7:0])
					`SAMC_PORT_LMPR: lmpr.raw <= bus.wdata;
					`SAMC_PORT_HMPR: hmpr.raw <= bus.wdata;
					`SAMC_PORT_BRDR: brdr     <= bus.wdata;
					`SAMC_PORT_EXTC: ext_c    <= bus.wdata;
					`SAMC_PORT_EXTD: ext_d    <= bus.wdata;
					default: ;
				endcase
			end
		end
	end

	assign ear = brdr[4]; // Beeper

	assign pages.lmpr    = lmpr;
	assign pages.hmpr    = hmpr;
	assign pages.ext_c   = ext_c;
	assign pages.ext_d   = ext_d;
	assign pages.ext_dis = ext_dis;

	// ======================================================================
	// Read data
	// ======================================================================
	assign io_dout_en = port_rd;

	always_comb begin
		case (bus.addr[7:0])
			`SAMC_PORT_LMPR: io_dout = lmpr.raw;
			`SAMC_PORT_HMPR: io_dout = hmpr.raw;
			`SAMC_PORT_STAT: io_dout = {3'b111, ~int_midi, 4'b1111};
			`SAMC_PORT_LPTD,
			`SAMC_PORT_LPTS: io_dout = 8'h00; // No printer fitted
			default:         io_dout = 8'hFF;
		endcase
	end

endmodule

/* source/mem_mapper.sv */
`timescale 1ns/1ps
`include "samc_defs.svh"

module mem_mapper import samc_pkg::*; (
	input  cpu_bus_t    bus,
	input  page_state_t pages,
	output mem_req_t    mem
);

	logic       rom0_sel;
	logic       rom1_sel;
	logic       ram_wp;
	logic       ext_win;
	logic       ext_sel;
	logic [4:0] page;
	logic [8:0] ext_page;

	assign rom0_sel = ~pages.lmpr.f.rom0_off & (bus.addr[15:14] == 2'b00);
	assign rom1_sel =  pages.lmpr.f.rom1_en  & (bus.addr[15:14] == 2'b11);
	assign ram_wp   =  pages.lmpr.f.wp       & (bus.addr[15:14] == 2'b00);
	assign ext_win  =  pages.hmpr.f.ext_ram  &  bus.addr[15];
	assign ext_sel  =  ext_win & ~pages.ext_dis;

	// Internal page by section, pairs of 16K pages
	always_comb begin
		case (bus.addr[15:14])
			2'b00:   page = pages.lmpr.f.page_ab;
			2'b01:   page = pages.lmpr.f.page_ab + 5'd1;
			2'b10:   page = pages.hmpr.f.page_cd;
			default: page = pages.hmpr.f.page_cd + 5'd1;
		endcase
	end

	assign ext_page = `SAMC_EXT_BASE + {1'b0, bus.addr[14] ? pages.ext_d : pages.ext_c};

	always_comb begin
		if (rom0_sel | rom1_sel)
			mem.ram_addr = `SAMC_RAM_AW'({`SAMC_ROM_PAGE, bus.addr[15], bus.addr[13:0]});
		else if (ext_sel)
			mem.ram_addr = `SAMC_RAM_AW'({ext_page, bus.addr[13:0]});
		else
			mem.ram_addr = `SAMC_RAM_AW'({page, bus.addr[13:0]});
	end

	assign mem.we = bus.mreq & bus.wr & ~(rom0_sel | rom1_sel | ram_wp)
		& ~(ext_win & pages.ext_dis);
	assign mem.rd = bus.mreq & bus.rd & ~bus.rfsh; // No refresh reads

endmodule

/* source/midi_tx_timer.sv */
`timescale 1ns/1ps
`include "samc_defs.svh"

module midi_tx_timer (
	input  logic clk_sys,
	input  logic reset,
	input  logic midi_wr,
	output logic int_midi,
	output logic midi_tx
);

	localparam int DIV_W  = $clog2(`SAMC_MEG_DIV);
	localparam int TIME_W = $clog2(`SAMC_MIDI_TIME);

	logic [DIV_W-1:0]  meg_cnt;
	logic              tick;
	logic [TIME_W-1:0] tx_time;
	logic              pending;

	// 1 MHz enable
	assign tick = (meg_cnt == DIV_W'(`SAMC_MEG_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset || tick)
			meg_cnt <= '0;
		else
			meg_cnt <= meg_cnt + 1'b1;
	end

	// ======================================================================
	// Transmit countdown
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tx_time  <= '0;
			pending  <= 1'b0;
			int_midi <= 1'b0;
			midi_tx  <= 1'b0;
		end else begin
			if (tick) begin
				if (tx_time != '0) begin
					tx_time <= tx_time - 1'b1;
					if (tx_time == TIME_W'(`SAMC_MIDI_INT_AT))
						int_midi <= 1'b1; // Near the end of the byte
				end else begin
					int_midi <= 1'b0;
					midi_tx  <= 1'b0;
					if (pending) begin
						midi_tx <= 1'b1;
						tx_time <= TIME_W'(`SAMC_MIDI_TIME - 1);
						pending <= 1'b0;
					end
				end
			end
			if (midi_wr)
				pending <= 1'b1; // Waits for the next tick
		end
	end

endmodule

/* source/vox_mixer.sv */
`timescale 1ns/1ps
`include "samc_defs.svh"

module vox_mixer import samc_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  cpu_bus_t bus,
	input  logic     port_wr,
	input  logic     ear,
	output audio_t   audio
);

	logic [7:0]                data;
	logic [7:0]                vox_l;
	logic [7:0]                vox_r;
	logic                      old_stb;
	logic [`SAMC_SAMPLE_W-1:0] ear_level;

	always_ff @(posedge clk_sys) begin
		if (port_wr && bus.addr[7:0] == `SAMC_PORT_LPTD)
			data <= bus.wdata;
	end

	// Strobe edge picks the channel
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vox_l   <= '0;
			vox_r   <= '0;
			old_stb <= 1'b0;
		end else if (port_wr && bus.addr[7:0] == `SAMC_PORT_LPTS) begin
			if (~old_stb & bus.wdata[0])
				vox_l <= data; // Rise
			if (old_stb & ~bus.wdata[0])
				vox_r <= data; // Fall
			old_stb <= bus.wdata[0];
		end
	end

	assign ear_level = `SAMC_SAMPLE_W'({ear, 15'd0});

	assign audio.left  = {vox_l, vox_l, 2'b00} + ear_level;
	assign audio.right = {vox_r, vox_r, 2'b00} + ear_level;

endmodule

/* source/samc_asic.sv */
`timescale 1ns/1ps

module samc_asic import samc_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	input  logic       ext_ram_off,
	output mem_req_t   mem,
	output logic [7:0] io_dout,
	output logic       io_dout_en,
	output audio_t     audio,
	output logic       int_midi,
	output logic       midi_tx
);

	page_state_t pages;
	logic        ear;
	logic        port_wr;
	logic        midi_wr;

	// ======================================================================
	// ASIC ports
	// ======================================================================
	asic_port_regs u_port_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.ext_ram_off (ext_ram_off),
		.int_midi    (int_midi),
		.pages       (pages),
		.ear         (ear),
		.port_wr     (port_wr),
		.midi_wr     (midi_wr),
		.io_dout     (io_dout),
		.io_dout_en  (io_dout_en)
	);

	mem_mapper u_mem_mapper (
		.bus   (bus),
		.pages (pages),
		.mem   (mem)
	);

	midi_tx_timer u_midi_tx_timer (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.midi_wr  (midi_wr),
		.int_midi (int_midi),
		.midi_tx  (midi_tx)
	);

	vox_mixer u_vox_mixer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.port_wr (port_wr),
		.ear     (ear),
		.audio   (audio)
	);

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys; // 100 MHz
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	end

endmodule

/* sim/tb_checker.sv */
`timescale 1ns/1ps
`include "samc_defs.svh"

module tb_checker import samc_pkg::*; (
	input  logic        clk_sys,
	input  logic        chk_req,
	input  logic [3:0]  chk_kind,
	input  logic [31:0] chk_exp,
	input  int          chk_id,
	input  logic [7:0]  io_dout,
	input  logic        io_dout_en,
	input  mem_req_t    mem,
	input  audio_t      audio,
	input  logic        midi_tx,
	input  logic        int_midi,
	output int          test_count,
	output int          fail_count
);

	int tests       = 0;
	int fails       = 0;
	int errs        = 0;
	int midi_cycles = 0;
	int int_cycles  = 0;

	assign test_count = tests;
	assign fail_count = fails;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s = %h, expected %h", $time, name, got, exp);
			errs++;
		end
	endtask

	function automatic string kind_name(input logic [3:0] kind);
		case (kind)
			4'h1:    return "io read";
			4'h2:    return "mem read";
			4'h3:    return "mem write";
			4'h6:    return "audio left";
			default: return "audio right";
		endcase
	endfunction

	// ======================================================================
	// Compare on the edge after each drive
	// ======================================================================
	always @(posedge clk_sys) begin
		if (chk_req) begin
			errs = 0;
			case (chk_kind)
				4'h1: begin
					compare("io_dout", 32'(io_dout), {24'd0, chk_exp[7:0]});
					compare("io_dout_en", 32'(io_dout_en), 32'd1);
				end
				4'h2, 4'h3: begin
					compare("mem.ram_addr", 32'(mem.ram_addr), {7'd0, chk_exp[24:0]});
					compare("mem.we", 32'(mem.we), 32'(chk_exp[28])); // We at bit 28
					compare("mem.rd", 32'(mem.rd), 32'(chk_kind == 4'h2));
					compare("io_dout_en", 32'(io_dout_en), 32'd0);
				end
				4'h6:    compare("audio.left", 32'(audio.left), {14'd0, chk_exp[17:0]});
				default: compare("audio.right", 32'(audio.right), {14'd0, chk_exp[17:0]});
			endcase
			tests++;
			if (errs != 0)
				fails++;
			$display("test %0d %s: %s", chk_id, kind_name(chk_kind), (errs == 0) ? "ok" : "wrong");
		end

		// MIDI pulse lengths in clk_sys cycles
		if (midi_tx) begin
			midi_cycles++;
			if (int_midi)
				int_cycles++;
		end else if (midi_cycles != 0) begin
			errs = 0;
			compare("midi_tx cycles", 32'(midi_cycles), 32'(`SAMC_MIDI_TIME * `SAMC_MEG_DIV));
			compare("int_midi cycles", 32'(int_cycles), 32'(`SAMC_MIDI_INT_AT * `SAMC_MEG_DIV));
			tests++;
			if (errs != 0)
				fails++;
			$display("test midi timing: %s", (errs == 0) ? "ok" : "wrong");
			midi_cycles = 0;
			int_cycles  = 0;
		end
	end

endmodule

/* sim/tb_samc_asic.sv */
`timescale 1ns/1ps
`include "samc_defs.svh"

module tb_samc_asic import samc_pkg::*; ();

	localparam int MAX_OPS = 64;

	logic        clk_sys;
	logic        clk_reset;
	logic        tb_reset;
	logic        reset;
	cpu_bus_t    bus;
	logic        ext_ram_off;
	mem_req_t    mem;
	logic [7:0]  io_dout;
	logic        io_dout_en;
	audio_t      audio;
	logic        int_midi;
	logic        midi_tx;
	logic        chk_req;
	logic [3:0]  chk_kind;
	logic [31:0] chk_exp;
	int          chk_id;
	int          test_count;
	int          fail_count;
	logic [31:0] vec_mem [0:4*MAX_OPS-1]; // Four words per operation
	int          num_ops;
	logic        loaded;

	assign reset = clk_reset | tb_reset; // Start-up reset or a reset vector

	tb_clock u_clock (
		.clk_sys (clk_sys),
		.reset   (clk_reset)
	);

	samc_asic u_dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bus         (bus),
		.ext_ram_off (ext_ram_off),
		.mem         (mem),
		.io_dout     (io_dout),
		.io_dout_en  (io_dout_en),
		.audio       (audio),
		.int_midi    (int_midi),
		.midi_tx     (midi_tx)
	);

	tb_checker u_checker (
		.clk_sys    (clk_sys),
		.chk_req    (chk_req),
		.chk_kind   (chk_kind),
		.chk_exp    (chk_exp),
		.chk_id     (chk_id),
		.io_dout    (io_dout),
		.io_dout_en (io_dout_en),
		.mem        (mem),
		.audio      (audio),
		.midi_tx    (midi_tx),
		.int_midi   (int_midi),
		.test_count (test_count),
		.fail_count (fail_count)
	);

	// ======================================================================
	// Bus operations
	// ======================================================================
	task automatic drive_cycle(input int n, input logic [3:0] kind,
		input logic [15:0] addr, input logic [7:0] data);
		bus       = '0;
		bus.addr  = addr;
		bus.wdata = data;
		case (kind)
			4'h0:    {bus.mreq, bus.iorq, bus.rd, bus.wr, bus.m1} = 5'b01011;
			4'h1:    {bus.mreq, bus.iorq, bus.rd, bus.wr, bus.m1} = 5'b01101;
			4'h2:    {bus.mreq, bus.iorq, bus.rd, bus.wr, bus.m1} = 5'b10100;
			4'h3:    {bus.mreq, bus.iorq, bus.rd, bus.wr, bus.m1} = 5'b10010;
			default: bus = '0; // Audio checks only look
		endcase
		chk_req  = (kind != 4'h0);
		chk_kind = kind;
		chk_exp  = vec_mem[4*n+3];
		chk_id   = n;
		@(posedge clk_sys);
		#1;
		chk_req = 1'b0;
		@(posedge clk_sys);
		#1;
		bus = '0; // Strobe low again before the next write
	endtask

	task automatic wait_for_event(input logic [7:0] sel);
		case (sel)
			8'h00:   wait (midi_tx);
			8'h01:   wait (int_midi);
			default: wait (!midi_tx);
		endcase
		@(posedge clk_sys);
		#1;
	endtask

	task automatic pulse_reset(input logic off);
		ext_ram_off = off;
		tb_reset    = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		tb_reset = 1'b0;
	endtask

	task automatic run_op(input int n);
		logic [3:0]  kind;
		logic [15:0] addr;
		logic [7:0]  data;
		kind = vec_mem[4*n][3:0];
		addr = vec_mem[4*n+1][15:0];
		data = vec_mem[4*n+2][7:0];
		@(posedge clk_sys);
		#1;
		case (kind)
			4'h4:    wait_for_event(data);
			4'h5:    pulse_reset(data[0]);
			default: drive_cycle(n, kind, addr, data);
		endcase
	endtask

	// Watchdog with 4 cycles per operation plus two MIDI bytes
	initial begin
		wait (loaded);
		#((num_ops * 4 + 2 * `SAMC_MIDI_TIME * `SAMC_MEG_DIV + 20) * 10);
		$display("watchdog timeout, the vector run did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		bus         = '0;
		ext_ram_off = 1'b0;
		tb_reset    = 1'b0;
		chk_req     = 1'b0;
		chk_kind    = '0;
		chk_exp     = '0;
		chk_id      = 0;
		num_ops     = 0;
		loaded      = 1'b0;
		for (int i = 0; i < 4*MAX_OPS; i++) begin
			vec_mem[i] = {28'(i), 4'hF};
		end
		$readmemh("sim/samc_vectors.txt", vec_mem);
		while (num_ops < MAX_OPS && vec_mem[4*num_ops][3:0] != 4'hF) begin
			num_ops++;
		end
		loaded = 1'b1;
		wait (clk_reset);
		wait (!reset);
		for (int n = 0; n < num_ops; n++) begin
			run_op(n);
		end
		@(posedge clk_sys);
		$display("checks %0d, ok %0d, wrong %0d", test_count, test_count - fail_count,
			fail_count);
		if (fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* sim/samc_vectors.txt */
// Columns in hex: kind, address, data, expected (mem ops have we at bit 28)
// Kind 0 io wr, 1 io rd, 2 mem rd, 3 mem wr, 4 wait, 5 reset, 6 left, 7 right, F end
1 00FA 00 00000000
1 00FB 00 00000000
2 0123 00 00080123
3 0123 55 00080123
2 C123 00 00004123
0 00FA 23 00000000
1 00FA 00 00000023
2 1234 00 0000D234
2 5234 00 00011234
0 00FB 06 00000000
1 00FB 00 00000006
2 9234 00 00019234
2 D234 00 0001D234
0 00FA 63 00000000
2 D234 00 00085234
3 D234 AA 00085234
3 0010 AA 1000C010
0 00FA A3 00000000
3 0010 AA 0000C010
3 4010 AA 10010010
0 0080 05 00000000
0 0081 12 00000000
0 00FB 86 00000000
2 9000 00 00115000
2 C100 00 00148100
3 9000 AA 10115000
5 0000 01 00000000
1 00FB 00 00000000
0 0080 05 00000000
0 00FB 86 00000000
3 9000 AA 00019000
5 0000 00 00000000
0 00FD 00 00000000
4 0000 00 00000000
1 00F9 00 000000FF
4 0000 01 00000000
1 00F9 00 000000EF
4 0000 02 00000000
1 00F9 00 000000FF
0 00E8 5A 00000000
0 00E9 01 00000000
6 0000 00 00016968
7 0000 00 00000000
0 00E8 C3 00000000
0 00E9 00 00000000
6 0000 00 00016968
7 0000 00 00030F0C
0 00FE 10 00000000
6 0000 00 0001E968
7 0000 00 00038F0C
F 0000 00 00000000

/* files.f */
+incdir+source
source/samc_pkg.sv
source/asic_port_regs.sv
source/mem_mapper.sv
source/midi_tx_timer.sv
source/vox_mixer.sv
source/samc_asic.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_samc_asic.sv

/* run_sim.sh */
#!/bin/bash
cd "$(dirname "$0")" \
	&& verilator --binary --timing -f files.f --top-module tb_samc_asic -o sim_samc_asic \
	&& ./obj_dir/sim_samc_asic | tee /dev/stderr | grep -q "Simulation passed" \
	&& echo "run ok" \
	|| { echo "run not ok"; exit 1; }
